/* logic/line_sram.sv */
`timescale 1ns/1ps

module line_sram #(
    parameter int SRAM_LINES = 256
) (
    input  logic                      clk,
    input  logic                      fill_en,
    input  lsu_store_pkg::sram_addr_t fill_addr,
    input  lsu_store_pkg::line_t      fill_data,
    input  logic                      rd_en,
    input  lsu_store_pkg::sram_addr_t rd_addr,
    output lsu_store_pkg::line_t      rd_data
);

    lsu_store_pkg::line_t mem [SRAM_LINES];

    // fill port, only used between jobs
    always_ff @(posedge clk) begin
        if (fill_en) begin
            mem[fill_addr] <= fill_data;
        end
    end

    // data lands one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* logic/lsu_store_pkg.sv */
package lsu_store_pkg;

    localparam int LINE_W      = 128;
    localparam int BEAT_W      = 64;
    localparam int BUS_ADDR_W  = 16;
    localparam int SRAM_ADDR_W = 8;
    localparam int BEAT_IDX_W  = 5;
    // byte step between consecutive beats on the bus
    localparam int BEAT_BYTES  = 8;

    typedef logic [LINE_W-1:0]      line_t;
    typedef logic [BEAT_W-1:0]      beat_t;
    typedef logic [BUS_ADDR_W-1:0]  bus_addr_t;
    typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;
    typedef logic [BEAT_IDX_W-1:0]  beat_idx_t;

    // owner of a read in flight
    typedef enum logic {src_issue, src_resend} req_src_e;

    typedef enum logic [1:0] {issue_idle, issue_sending, issue_waiting} issue_state_e;

    typedef enum logic [1:0] {resend_idle, resend_collecting, resend_retrying} resend_state_e;

    // two beats per line, even beat in the low half
    function automatic sram_addr_t beat_line(sram_addr_t base, beat_idx_t idx);
        return base + sram_addr_t'(idx >> 1);
    endfunction

    function automatic bus_addr_t beat_bus_addr(bus_addr_t base, beat_idx_t idx);
        return base + bus_addr_t'(idx) * bus_addr_t'(BEAT_BYTES);
    endfunction

endpackage

/* logic/resend_engine.sv */
`timescale 1ns/1ps

module resend_engine #(
    parameter int MAX_BEATS = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    store_job_if.tracker             job,
    input  logic                     resp_valid,
    input  lsu_store_pkg::beat_idx_t resp_beat,
    input  logic                     resp_err,
    sram_rd_if.requester             rd,
    output logic                     job_done
);

    lsu_store_pkg::resend_state_e state;
    lsu_store_pkg::bus_addr_t     bus_base;
    lsu_store_pkg::sram_addr_t    sram_base;
    lsu_store_pkg::beat_idx_t     beats;
    lsu_store_pkg::beat_idx_t     last_idx;
    lsu_store_pkg::beat_idx_t     pick;
    lsu_store_pkg::beat_idx_t     cur_beat;
    logic [MAX_BEATS-1:0]         clean;
    logic [MAX_BEATS-1:0]         retry;
    logic [MAX_BEATS-1:0]         job_mask;
    logic                         req_q;
    logic                         all_clean;
    logic                         done;

    assign last_idx = (beats == '0) ? lsu_store_pkg::beat_idx_t'(MAX_BEATS - 1)
                                    : beats - 1'b1;

    // lowest pending retry first
    always_comb begin
        pick = '0;
        for (int i = MAX_BEATS - 1; i >= 0; i--) begin
            if (retry[i]) begin
                pick = lsu_store_pkg::beat_idx_t'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < MAX_BEATS; i++) begin
            job_mask[i] = (lsu_store_pkg::beat_idx_t'(i) <= last_idx);
        end
    end

    assign all_clean = &(clean | ~job_mask);
    assign done      = (state != lsu_store_pkg::resend_idle) && all_clean;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_store_pkg::resend_idle;
            clean <= '0;
            retry <= '0;
            req_q <= 1'b0;
        end else if (job.start) begin
            state <= lsu_store_pkg::resend_collecting;
            clean <= '0;
            retry <= '0;
            req_q <= 1'b0;
        end else if (done) begin
            state <= lsu_store_pkg::resend_idle;
            req_q <= 1'b0;
        end else if (state != lsu_store_pkg::resend_idle) begin
            if (rd.gnt) begin
                retry[cur_beat] <= 1'b0;
            end
            // a failed copy queues the beat again
            if (resp_valid) begin
                if (resp_err) begin
                    retry[resp_beat] <= 1'b1;
                end else begin
                    clean[resp_beat] <= 1'b1;
                end
            end
            case (state)
                lsu_store_pkg::resend_collecting: begin
                    if (|retry) begin
                        state <= lsu_store_pkg::resend_retrying;
                    end
                end
                lsu_store_pkg::resend_retrying: begin
                    if (req_q) begin
                        if (rd.gnt) begin
                            req_q <= 1'b0;
                        end
                    end else if (|retry) begin
                        req_q <= 1'b1;
                    end else begin
                        state <= lsu_store_pkg::resend_collecting;
                    end
                end
                default: state <= lsu_store_pkg::resend_idle;
            endcase
        end
    end

    // held steady while the request waits for a credit
    always_ff @(posedge clk) begin
        if (state == lsu_store_pkg::resend_retrying && !req_q) begin
            cur_beat <= pick;
        end
    end

    always_ff @(posedge clk) begin
        if (job.start) begin
            bus_base  <= job.bus_base;
            sram_base <= job.sram_base;
            beats     <= job.beats;
        end
    end

    assign rd.req       = req_q;
    assign rd.beat      = cur_beat;
    assign rd.sram_addr = lsu_store_pkg::beat_line(sram_base, cur_beat);
    assign rd.bus_addr  = lsu_store_pkg::beat_bus_addr(bus_base, cur_beat);

    assign job.done = done;
    assign job_done = done;

endmodule

/* logic/sram_arbiter.sv */
`timescale 1ns/1ps

module sram_arbiter #(
    parameter int BUS_CREDITS = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    sram_rd_if.arbiter                issue_rd,
    sram_rd_if.arbiter                resend_rd,
    output logic                      rd_en,
    output lsu_store_pkg::sram_addr_t rd_addr,
    input  lsu_store_pkg::line_t      rd_data,
    input  logic                      credit_ret,
    output logic                      wr_valid,
    output lsu_store_pkg::bus_addr_t  wr_addr,
    output lsu_store_pkg::beat_t      wr_data,
    output lsu_store_pkg::beat_idx_t  wr_beat
);

    localparam int CNT_W = $clog2(BUS_CREDITS + 1);

    logic [CNT_W-1:0]         credit_cnt;
    logic                     has_credit;
    logic                     grant;
    lsu_store_pkg::req_src_e  gnt_src;

    assign has_credit = (credit_cnt != '0);

    // resend engine wins over the issuer
    assign gnt_src = resend_rd.req ? lsu_store_pkg::src_resend : lsu_store_pkg::src_issue;

    assign resend_rd.gnt = resend_rd.req && has_credit;
    assign issue_rd.gnt  = issue_rd.req && !resend_rd.req && has_credit;
    assign grant         = resend_rd.gnt || issue_rd.gnt;

    // read launches in the grant cycle
    assign rd_en   = grant;
    assign rd_addr = (gnt_src == lsu_store_pkg::src_resend) ? resend_rd.sram_addr
                                                            : issue_rd.sram_addr;

    // one credit per granted read, one back per credit_ret
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CNT_W'(BUS_CREDITS);
        end else if (grant && !credit_ret) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!grant && credit_ret) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= grant;
        end
    end

    // beat fields follow the read by one cycle
    always_ff @(posedge clk) begin
        if (grant) begin
            if (gnt_src == lsu_store_pkg::src_resend) begin
                wr_addr <= resend_rd.bus_addr;
                wr_beat <= resend_rd.beat;
            end else begin
                wr_addr <= issue_rd.bus_addr;
                wr_beat <= issue_rd.beat;
            end
        end
    end

    // odd beats sit in the upper half of the line
    assign wr_data = wr_beat[0] ? rd_data[lsu_store_pkg::BEAT_W +: lsu_store_pkg::BEAT_W]
                                : rd_data[0 +: lsu_store_pkg::BEAT_W];

endmodule

/* logic/sram_rd_if.sv */
`timescale 1ns/1ps

interface sram_rd_if;

    // request fields stay put until gnt
    logic                      req;
    lsu_store_pkg::sram_addr_t sram_addr;
    lsu_store_pkg::beat_idx_t  beat;
    lsu_store_pkg::bus_addr_t  bus_addr;
    logic                      gnt;

    modport requester (
        output req, sram_addr, beat, bus_addr,
        input  gnt
    );

    modport arbiter (
        input  req, sram_addr, beat, bus_addr,
        output gnt
    );

endinterface

/* logic/store_issuer.sv */
`timescale 1ns/1ps

module store_issuer #(
    parameter int MAX_BEATS = 32
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cmd_valid,
    output logic                      cmd_ready,
    input  lsu_store_pkg::bus_addr_t  cmd_bus_addr,
    input  lsu_store_pkg::sram_addr_t cmd_sram_base,
    input  lsu_store_pkg::beat_idx_t  cmd_beats,
    store_job_if.issuer               job,
    sram_rd_if.requester              rd
);

    lsu_store_pkg::issue_state_e state;
    lsu_store_pkg::bus_addr_t    bus_base;
    lsu_store_pkg::sram_addr_t   sram_base;
    lsu_store_pkg::beat_idx_t    beats;
    lsu_store_pkg::beat_idx_t    idx;
    lsu_store_pkg::beat_idx_t    last_idx;
    logic                        start_q;
    logic                        accept;

    assign cmd_ready = (state == lsu_store_pkg::issue_idle);
    assign accept    = cmd_valid && cmd_ready;

    // a count of zero stands for a full MAX_BEATS job
    assign last_idx = (beats == '0) ? lsu_store_pkg::beat_idx_t'(MAX_BEATS - 1)
                                    : beats - 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= lsu_store_pkg::issue_idle;
            start_q <= 1'b0;
            idx     <= '0;
        end else begin
            start_q <= accept;
            case (state)
                lsu_store_pkg::issue_idle: begin
                    if (accept) begin
                        state <= lsu_store_pkg::issue_sending;
                        idx   <= '0;
                    end
                end
                lsu_store_pkg::issue_sending: begin
                    if (rd.gnt) begin
                        if (idx == last_idx) begin
                            state <= lsu_store_pkg::issue_waiting;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                lsu_store_pkg::issue_waiting: begin
                    // resend engine owns the job until done
                    if (job.done) begin
                        state <= lsu_store_pkg::issue_idle;
                    end
                end
                default: state <= lsu_store_pkg::issue_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bus_base  <= cmd_bus_addr;
            sram_base <= cmd_sram_base;
            beats     <= cmd_beats;
        end
    end

    assign job.start     = start_q;
    assign job.bus_base  = bus_base;
    assign job.sram_base = sram_base;
    assign job.beats     = beats;

    // first request waits out the start pulse
    assign rd.req       = (state == lsu_store_pkg::issue_sending) && !start_q;
    assign rd.beat      = idx;
    assign rd.sram_addr = lsu_store_pkg::beat_line(sram_base, idx);
    assign rd.bus_addr  = lsu_store_pkg::beat_bus_addr(bus_base, idx);

endmodule

/* logic/store_job_if.sv */
`timescale 1ns/1ps

interface store_job_if;

    logic                      start;
    lsu_store_pkg::bus_addr_t  bus_base;
    lsu_store_pkg::sram_addr_t sram_base;
    lsu_store_pkg::beat_idx_t  beats;
    logic                      done;

    modport issuer (
        output start, bus_base, sram_base, beats,
        input  done
    );

    modport tracker (
        input  start, bus_base, sram_base, beats,
        output done
    );

endinterface

/* logic/store_unit.sv */
`timescale 1ns/1ps

module store_unit #(
    parameter int BUS_CREDITS = 4,
    parameter int MAX_BEATS   = 32,
    parameter int SRAM_LINES  = 256
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fill_en,
    input  lsu_store_pkg::sram_addr_t fill_addr,
    input  lsu_store_pkg::line_t      fill_data,
    input  logic                      cmd_valid,
    output logic                      cmd_ready,
    input  lsu_store_pkg::bus_addr_t  cmd_bus_addr,
    input  lsu_store_pkg::sram_addr_t cmd_sram_base,
    input  lsu_store_pkg::beat_idx_t  cmd_beats,
    output logic                      wr_valid,
    output lsu_store_pkg::bus_addr_t  wr_addr,
    output lsu_store_pkg::beat_t      wr_data,
    output lsu_store_pkg::beat_idx_t  wr_beat,
    input  logic                      credit_ret,
    input  logic                      resp_valid,
    input  lsu_store_pkg::beat_idx_t  resp_beat,
    input  logic                      resp_err,
    output logic                      job_done
);

    logic                      rd_en;
    lsu_store_pkg::sram_addr_t rd_addr;
    lsu_store_pkg::line_t      rd_data;

    sram_rd_if   issue_rd ();
    sram_rd_if   resend_rd ();
    store_job_if job ();

    line_sram #(
        .SRAM_LINES (SRAM_LINES)
    ) i_line_sram (
        .clk       (clk),
        .fill_en   (fill_en),
        .fill_addr (fill_addr),
        .fill_data (fill_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    sram_arbiter #(
        .BUS_CREDITS (BUS_CREDITS)
    ) i_arbiter (
        .clk        (clk),
        .rst        (rst),
        .issue_rd   (issue_rd),
        .resend_rd  (resend_rd),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .credit_ret (credit_ret),
        .wr_valid   (wr_valid),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_beat    (wr_beat)
    );

    store_issuer #(
        .MAX_BEATS (MAX_BEATS)
    ) i_issuer (
        .clk           (clk),
        .rst           (rst),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .cmd_bus_addr  (cmd_bus_addr),
        .cmd_sram_base (cmd_sram_base),
        .cmd_beats     (cmd_beats),
        .job           (job),
        .rd            (issue_rd)
    );

    resend_engine #(
        .MAX_BEATS (MAX_BEATS)
    ) i_resend (
        .clk        (clk),
        .rst        (rst),
        .job        (job),
        .resp_valid (resp_valid),
        .resp_beat  (resp_beat),
        .resp_err   (resp_err),
        .rd         (resend_rd),
        .job_done   (job_done)
    );

endmodule

/* store_unit.f */
logic/lsu_store_pkg.sv
logic/sram_rd_if.sv
logic/store_job_if.sv
logic/line_sram.sv
logic/sram_arbiter.sv
logic/store_issuer.sv
logic/resend_engine.sv
logic/store_unit.sv
tests/store_unit_tb.sv

/* tests/store_unit_tb.sv */
`timescale 1ns/1ps

module store_unit_tb;

    localparam int BUS_CREDITS    = 4;
    localparam int MAX_BEATS      = 32;
    localparam int FILL_LINES     = 16;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_JOBS       = 7;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 400 * NUM_JOBS;
    localparam int SLOW_CREDIT    = 30;

    logic                      clk;
    logic                      rst;
    logic                      fill_en;
    lsu_store_pkg::sram_addr_t fill_addr;
    lsu_store_pkg::line_t      fill_data;
    logic                      cmd_valid;
    logic                      cmd_ready;
    lsu_store_pkg::bus_addr_t  cmd_bus_addr;
    lsu_store_pkg::sram_addr_t cmd_sram_base;
    lsu_store_pkg::beat_idx_t  cmd_beats;
    logic                      wr_valid;
    lsu_store_pkg::bus_addr_t  wr_addr;
    lsu_store_pkg::beat_t      wr_data;
    lsu_store_pkg::beat_idx_t  wr_beat;
    logic                      credit_ret = 1'b0;
    logic                      resp_valid = 1'b0;
    lsu_store_pkg::beat_idx_t  resp_beat  = '0;
    logic                      resp_err   = 1'b0;
    logic                      job_done;

    integer seed = 32'h53db11be;

    // mirror of the filled lines and the state of the running job
    lsu_store_pkg::line_t      fill_mem [256];
    lsu_store_pkg::sram_addr_t job_sbase;
    lsu_store_pkg::bus_addr_t  job_bbase;
    int                        sends      [MAX_BEATS];
    int                        exp_sends  [MAX_BEATS];
    int                        err_left   [MAX_BEATS];
    bit                        clean_seen [MAX_BEATS];
    bit                        job_active  = 1'b0;
    bit                        slow_credit = 1'b0;
    int                        cycle       = 0;
    int                        outstanding = 0;

    // bus model bookkeeping, one entry per beat taken
    int                        credit_due  [$];
    int                        resp_due    [$];
    lsu_store_pkg::beat_idx_t  resp_beat_q [$];
    bit                        resp_err_q  [$];

    store_unit i_store_unit (
        .clk           (clk),
        .rst           (rst),
        .fill_en       (fill_en),
        .fill_addr     (fill_addr),
        .fill_data     (fill_data),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .cmd_bus_addr  (cmd_bus_addr),
        .cmd_sram_base (cmd_sram_base),
        .cmd_beats     (cmd_beats),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_beat       (wr_beat),
        .credit_ret    (credit_ret),
        .resp_valid    (resp_valid),
        .resp_beat     (resp_beat),
        .resp_err      (resp_err),
        .job_done      (job_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // two beats per line, even beat in the low half
    function automatic lsu_store_pkg::beat_t expected_beat(input lsu_store_pkg::sram_addr_t base,
                                                           input lsu_store_pkg::beat_idx_t idx);
        lsu_store_pkg::line_t line;
        line = fill_mem[(int'(base) + int'(idx) / 2) % 256];
        if (idx % 2 == 1) begin
            return line[127:64];
        end else begin
            return line[63:0];
        end
    endfunction

    function automatic lsu_store_pkg::bus_addr_t expected_addr(input lsu_store_pkg::bus_addr_t base,
                                                               input lsu_store_pkg::beat_idx_t idx);
        return lsu_store_pkg::bus_addr_t'(int'(base) + int'(idx) * 8);
    endfunction

    function automatic int credit_delay();
        if (slow_credit) begin
            return SLOW_CREDIT;
        end else begin
            return 1 + int'({$random(seed)} % 4);
        end
    endfunction

    // index of the first entry that is due, or -1
    function automatic int first_due(input int due[$], input int now);
        int k;
        k = -1;
        for (int i = due.size() - 1; i >= 0; i--) begin
            if (due[i] <= now) begin
                k = i;
            end
        end
        return k;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_beat(input lsu_store_pkg::beat_idx_t idx,
                              input lsu_store_pkg::beat_t     exp_data,
                              input lsu_store_pkg::beat_t     act_data,
                              input lsu_store_pkg::bus_addr_t exp_addr,
                              input lsu_store_pkg::bus_addr_t act_addr);
        if (act_data !== exp_data) begin
            fail_run($sformatf("Mismatch at %0t: wr_data of beat %0d expected %h actual %h",
                               $time, idx, exp_data, act_data));
        end
        if (act_addr !== exp_addr) begin
            fail_run($sformatf("Mismatch at %0t: wr_addr of beat %0d expected %h actual %h",
                               $time, idx, exp_addr, act_addr));
        end
    endtask

    task automatic check_done(input string name, input int exp_val, input int act_val);
        if (act_val != exp_val) begin
            fail_run($sformatf("Mismatch at %0t: %s expected %0d actual %0d",
                               $time, name, exp_val, act_val));
        end
    endtask

    task automatic inject_error(input lsu_store_pkg::beat_idx_t idx, input int times);
        err_left[idx] = times;
    endtask

    task automatic fill_lines();
        lsu_store_pkg::line_t line;
        for (int i = 0; i < FILL_LINES; i++) begin
            line = {$random(seed), $random(seed), $random(seed), $random(seed)};
            @(posedge clk);
            fill_en   <= 1'b1;
            fill_addr <= lsu_store_pkg::sram_addr_t'(i);
            fill_data <= line;
            fill_mem[i] = line;
        end
        @(posedge clk);
        fill_en <= 1'b0;
    endtask

    task automatic run_job(input lsu_store_pkg::sram_addr_t sbase,
                           input lsu_store_pkg::bus_addr_t  bbase,
                           input lsu_store_pkg::beat_idx_t  n);
        do begin
            @(negedge clk);
        end while (!cmd_ready);
        @(posedge clk);
        job_sbase = sbase;
        job_bbase = bbase;
        for (int i = 0; i < MAX_BEATS; i++) begin
            sends[i]      = 0;
            clean_seen[i] = 1'b0;
            exp_sends[i]  = (i < n) ? 1 + err_left[i] : 0;
        end
        cmd_valid     <= 1'b1;
        cmd_bus_addr  <= bbase;
        cmd_sram_base <= sbase;
        cmd_beats     <= n;
        // cmd_ready is high, so the job is taken at this edge
        @(posedge clk);
        cmd_valid  <= 1'b0;
        job_active = 1'b1;
        while (job_active) begin
            @(posedge clk);
        end
    endtask

    // bus side: credits and responses, one of each per cycle at most
    always @(posedge clk) begin
        int k;
        cycle = cycle + 1;
        if (cycle > TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
        credit_ret <= 1'b0;
        resp_valid <= 1'b0;
        resp_err   <= 1'b0;
        k = first_due(credit_due, cycle);
        if (k >= 0) begin
            credit_due.delete(k);
            credit_ret  <= 1'b1;
            outstanding = outstanding - 1;
        end
        k = first_due(resp_due, cycle);
        if (k >= 0) begin
            resp_valid <= 1'b1;
            resp_beat  <= resp_beat_q[k];
            resp_err   <= resp_err_q[k];
            if (!resp_err_q[k]) begin
                clean_seen[resp_beat_q[k]] = 1'b1;
            end
            resp_due.delete(k);
            resp_beat_q.delete(k);
            resp_err_q.delete(k);
        end
    end

    // compare process, samples DUT outputs mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (wr_valid) begin
                check_beat(wr_beat, expected_beat(job_sbase, wr_beat), wr_data,
                           expected_addr(job_bbase, wr_beat), wr_addr);
                sends[wr_beat] = sends[wr_beat] + 1;
                outstanding = outstanding + 1;
                if (outstanding > BUS_CREDITS) begin
                    fail_run("More beats outstanding on the bus than it has credits for");
                end
                credit_due.push_back(cycle + credit_delay());
                resp_due.push_back(cycle + 1 + int'({$random(seed)} % 8));
                resp_beat_q.push_back(wr_beat);
                if (err_left[wr_beat] > 0) begin
                    err_left[wr_beat] = err_left[wr_beat] - 1;
                    resp_err_q.push_back(1'b1);
                end else begin
                    resp_err_q.push_back(1'b0);
                end
            end
            if (job_active && cmd_ready) begin
                fail_run("cmd_ready was high while a job was still running");
            end
            if (job_done) begin
                if (!job_active) begin
                    fail_run("job_done pulsed with no job running");
                end
                if (resp_due.size() != 0) begin
                    fail_run("job_done came before every beat had its response");
                end
                for (int i = 0; i < MAX_BEATS; i++) begin
                    check_done($sformatf("sends of beat %0d", i), exp_sends[i], sends[i]);
                    check_done($sformatf("clean response of beat %0d", i),
                               (exp_sends[i] > 0) ? 1 : 0, int'(clean_seen[i]));
                end
                job_active = 1'b0;
            end
        end
    end

    initial begin
        rst           = 1'b1;
        fill_en       = 1'b0;
        fill_addr     = '0;
        fill_data     = '0;
        cmd_valid     = 1'b0;
        cmd_bus_addr  = '0;
        cmd_sram_base = '0;
        cmd_beats     = '0;
        foreach (fill_mem[i]) begin
            fill_mem[i] = '0;
        end
        foreach (err_left[i]) begin
            err_left[i] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        fill_lines();
        run_job(8'd0, 16'h1000, 5'd6);
        // nonzero line base with an odd beat count
        run_job(8'd5, 16'h2008, 5'd7);
        inject_error(5'd3, 1);
        inject_error(5'd7, 1);
        inject_error(5'd8, 1);
        run_job(8'd2, 16'h3000, 5'd12);
        // beat 4 fails on its first two copies
        inject_error(5'd4, 2);
        inject_error(5'd9, 1);
        run_job(8'd3, 16'h4010, 5'd10);
        slow_credit = 1'b1;
        run_job(8'd0, 16'h5000, 5'd16);
        slow_credit = 1'b0;
        // back to back jobs
        inject_error(5'd1, 1);
        run_job(8'd10, 16'h6000, 5'd5);
        run_job(8'd12, 16'h6100, 5'd4);
        do begin
            @(negedge clk);
        end while (!cmd_ready);
        $display("Simulation PASSED");
        $finish;
    end

endmodule
